/* common/soc_pkg.sv */
// ----------------------------------------
// shared definitions for the system-control slice
// bus request/response, register map, reload states
// ----------------------------------------

package soc_pkg;

	// widths
	localparam int DATA_W = 32;
	localparam int ADDR_W = 32;
	localparam int STRB_W = 4;
	localparam int GENIO_W = 30;
	localparam int BTN_W = 8;
	localparam int LED_W = 9;
	localparam int FSEL_CNT_W = 3;

	// fixed values
	localparam logic [DATA_W-1:0] SOC_VERSION = 32'h0000_8000;
	localparam logic [DATA_W-1:0] BUS_ERR_DATA = 32'hDEAD_BEEF;
	localparam logic [23:0] RELOAD_KEY = 24'hD0F1A5;

	// flash mux settle countdown, clock high while count is in [LO, HI]
	localparam logic [FSEL_CNT_W-1:0] FSEL_DELAY = 3'd7;
	localparam logic [FSEL_CNT_W-1:0] FSEL_CLK_HI = 3'd5;
	localparam logic [FSEL_CNT_W-1:0] FSEL_CLK_LO = 3'd3;

	// ----------------------------------------
	// bus
	// ----------------------------------------
	typedef struct packed {
		logic valid;
		logic [ADDR_W-1:0] addr;
		logic [DATA_W-1:0] wdata;
		// all zero means read
		logic [STRB_W-1:0] wstrb;
	} bus_req_t;

	typedef struct packed {
		logic ready;
		logic [DATA_W-1:0] rdata;
	} bus_rsp_t;

	// address bits 31:28, anything else is unmapped
	typedef enum logic [3:0] {
		REGION_MISC = 4'h2
	} region_e;

	// word offset from address bits 6:2
	typedef enum logic [4:0] {
		REG_LED = 5'd0,
		REG_BTN = 5'd1,
		REG_SOC_VER = 5'd2,
		REG_FLASH_SEL = 5'd13,
		REG_GENIO_IN = 5'd17,
		REG_GENIO_OUT = 5'd18,
		REG_GENIO_OE = 5'd19,
		REG_GENIO_W2S = 5'd20,
		REG_GENIO_W2C = 5'd21
	} misc_reg_e;

	// ----------------------------------------
	// flash select / reload
	// ----------------------------------------
	typedef struct packed {
		logic strobe;
		logic arm;
	} fsel_req_t;

	typedef enum logic [1:0] {
		RL_IDLE,
		RL_ARMED,
		RL_RELOAD
	} reload_state_e;

endpackage

/* misc/fsel_timer.sv */
// ----------------------------------------
// flash select settle countdown
// clocks the flash mux flop, flags expiry
// ----------------------------------------
`timescale 1ns/1ns

module fsel_timer (
	input  logic clk48m,
	input  logic rst,
	input  logic start_i,
	output logic fsel_c_o,
	output logic expired_o
);
	import soc_pkg::*;

	logic [FSEL_CNT_W-1:0] count_q;

	// a restart during a countdown simply reloads
	always_ff @(posedge clk48m) begin
		if (rst) begin
			count_q <= '0;
		end else if (start_i) begin
			count_q <= FSEL_DELAY;
		end else if (count_q != '0) begin
			count_q <= count_q - 1'b1;
		end
	end

	// mux clock sits in the middle of the window so fsel_d is stable on both sides
	assign fsel_c_o = (count_q <= FSEL_CLK_HI) && (count_q >= FSEL_CLK_LO);
	assign expired_o = (count_q == FSEL_CNT_W'(1));

endmodule

/* misc/reload_fsm.sv */
// ----------------------------------------
// fpga reload sequencer
// arms on a keyed flash select write, pulls programn on expiry
// ----------------------------------------
`timescale 1ns/1ns

module reload_fsm (
	input  logic clk48m,
	input  logic rst,
	input  soc_pkg::fsel_req_t fsel_req_i,
	input  logic expired_i,
	output logic timer_start_o,
	output logic programn_o
);
	import soc_pkg::*;

	reload_state_e state_q;
	reload_state_e state_d;
	logic start_q;

	// every flash select write restarts the settle countdown
	always_ff @(posedge clk48m) begin
		if (rst) begin
			start_q <= 1'b0;
			state_q <= RL_IDLE;
		end else begin
			start_q <= fsel_req_i.strobe;
			state_q <= state_d;
		end
	end

	always_comb begin
		state_d = state_q;
		case (state_q)
			RL_IDLE: begin
				if (fsel_req_i.strobe && fsel_req_i.arm) begin
					state_d = RL_ARMED;
				end
			end
			RL_ARMED: begin
				// a new write decides again, its countdown takes over
				if (fsel_req_i.strobe) begin
					state_d = fsel_req_i.arm ? RL_ARMED : RL_IDLE;
				end else if (expired_i) begin
					state_d = RL_RELOAD;
				end
			end
			RL_RELOAD: begin
				// only reset leaves, the fpga is reconfiguring anyway
				state_d = RL_RELOAD;
			end
			default: begin
				state_d = RL_IDLE;
			end
		endcase
	end

	assign timer_start_o = start_q;
	assign programn_o = (state_q != RL_RELOAD);

endmodule

/* misc/misc_regs.sv */
// ----------------------------------------
// misc register bank
// leds, buttons, version, general i/o, flash select
// ----------------------------------------
`timescale 1ns/1ns

module misc_regs (
	input  logic clk48m,
	input  logic rst,
	input  logic misc_sel_i,
	input  soc_pkg::bus_req_t bus_req_i,
	input  logic [soc_pkg::BTN_W-1:0] btn_i,
	input  logic [soc_pkg::GENIO_W-1:0] genio_in_i,
	output logic [soc_pkg::DATA_W-1:0] misc_rdata_o,
	output logic [soc_pkg::LED_W-1:0] led_o,
	output logic [soc_pkg::GENIO_W-1:0] genio_out_o,
	output logic [soc_pkg::GENIO_W-1:0] genio_oe_o,
	output logic fsel_d_o,
	output soc_pkg::fsel_req_t fsel_req_o
);
	import soc_pkg::*;

	misc_reg_e reg_off;
	logic wr_en;
	logic [GENIO_W-1:0] wdata_genio;
	logic [BTN_W-1:0] btn_n;

	logic [LED_W-1:0] led_q;
	logic [GENIO_W-1:0] genio_out_q;
	logic [GENIO_W-1:0] genio_oe_q;
	logic fsel_d_q;
	fsel_req_t fsel_req_q;

	assign reg_off = misc_reg_e'(bus_req_i.addr[6:2]);
	// any write with byte lane 0 enabled counts as a register write
	assign wr_en = misc_sel_i && bus_req_i.wstrb[0];
	assign wdata_genio = bus_req_i.wdata[GENIO_W-1:0];
	// buttons are active low on the board
	assign btn_n = ~btn_i;

	// ----------------------------------------
	// write decode
	// ----------------------------------------
	always_ff @(posedge clk48m) begin
		if (rst) begin
			led_q <= '0;
			genio_out_q <= '0;
			genio_oe_q <= '0;
			fsel_d_q <= 1'b0;
			fsel_req_q <= '0;
		end else begin
			// strobe is a single cycle pulse
			fsel_req_q.strobe <= 1'b0;
			fsel_req_q.arm <= 1'b0;
			if (wr_en) begin
				case (reg_off)
					REG_LED: begin
						led_q <= bus_req_i.wdata[LED_W-1:0];
					end
					REG_GENIO_OUT: begin
						genio_out_q <= wdata_genio;
					end
					REG_GENIO_OE: begin
						genio_oe_q <= wdata_genio;
					end
					REG_GENIO_W2S: begin
						genio_out_q <= genio_out_q | wdata_genio;
					end
					REG_GENIO_W2C: begin
						genio_out_q <= genio_out_q & ~wdata_genio;
					end
					REG_FLASH_SEL: begin
						fsel_d_q <= bus_req_i.wdata[0];
						fsel_req_q.strobe <= 1'b1;
						// key in the upper bits asks for a reload after the switch
						fsel_req_q.arm <= (bus_req_i.wdata[31:8] == RELOAD_KEY);
					end
					default: begin
					end
				endcase
			end
		end
	end

	// ----------------------------------------
	// readback
	// ----------------------------------------
	always_comb begin
		case (reg_off)
			REG_LED: begin
				misc_rdata_o = {{(DATA_W-LED_W){1'b0}}, led_q};
			end
			REG_BTN: begin
				misc_rdata_o = {{(DATA_W-BTN_W){1'b0}}, btn_n};
			end
			REG_SOC_VER: begin
				misc_rdata_o = SOC_VERSION;
			end
			REG_FLASH_SEL: begin
				misc_rdata_o = {{(DATA_W-1){1'b0}}, fsel_d_q};
			end
			REG_GENIO_IN: begin
				misc_rdata_o = {{(DATA_W-GENIO_W){1'b0}}, genio_in_i};
			end
			REG_GENIO_OUT: begin
				misc_rdata_o = {{(DATA_W-GENIO_W){1'b0}}, genio_out_q};
			end
			REG_GENIO_OE: begin
				misc_rdata_o = {{(DATA_W-GENIO_W){1'b0}}, genio_oe_q};
			end
			default: begin
				// write-only and unmapped offsets
				misc_rdata_o = '0;
			end
		endcase
	end

	assign led_o = led_q;
	assign genio_out_o = genio_out_q;
	assign genio_oe_o = genio_oe_q;
	assign fsel_d_o = fsel_d_q;
	assign fsel_req_o = fsel_req_q;

endmodule

/* source/bus_decoder.sv */
// ----------------------------------------
// cpu bus region decode
// selects the misc block, answers unmapped regions with an error
// ----------------------------------------
`timescale 1ns/1ns

module bus_decoder (
	input  logic clk48m,
	input  logic rst,
	input  soc_pkg::bus_req_t bus_req_i,
	input  logic [soc_pkg::DATA_W-1:0] misc_rdata_i,
	output logic misc_sel_o,
	output soc_pkg::bus_rsp_t bus_rsp_o,
	output logic bus_err_irq_o
);
	import soc_pkg::*;

	region_e region;
	logic is_misc;
	logic hit_misc;
	logic hit_err;
	// low until the first edge out of reset
	logic rsp_en;

	assign region = region_e'(bus_req_i.addr[31:28]);
	assign is_misc = (region == REGION_MISC);

	always_ff @(posedge clk48m) begin
		if (rst) begin
			rsp_en <= 1'b0;
		end else begin
			rsp_en <= 1'b1;
		end
	end

	assign hit_misc = rsp_en && bus_req_i.valid && is_misc;
	assign hit_err = rsp_en && bus_req_i.valid && !is_misc;

	assign misc_sel_o = hit_misc;
	// error pulse lasts exactly as long as the faulting access
	assign bus_err_irq_o = hit_err;

	// ----------------------------------------
	// response mux
	// ----------------------------------------
	// ready never waits, every access completes in its own cycle
	always_comb begin
		bus_rsp_o.ready = hit_misc || hit_err;
		if (is_misc) begin
			bus_rsp_o.rdata = misc_rdata_i;
		end else begin
			bus_rsp_o.rdata = BUS_ERR_DATA;
		end
	end

endmodule

/* source/soc_misc_top.sv */
// ----------------------------------------
// system-control slice top
// bus decode, misc registers, flash select and reload
// ----------------------------------------
`timescale 1ns/1ns

module soc_misc_top (
	input  logic clk48m,
	input  logic rst,
	input  soc_pkg::bus_req_t bus_req_i,
	output soc_pkg::bus_rsp_t bus_rsp_o,
	input  logic [soc_pkg::BTN_W-1:0] btn_i,
	input  logic [soc_pkg::GENIO_W-1:0] genio_in_i,
	output logic [soc_pkg::GENIO_W-1:0] genio_out_o,
	output logic [soc_pkg::GENIO_W-1:0] genio_oe_o,
	output logic [soc_pkg::LED_W-1:0] led_o,
	output logic fsel_d_o,
	output logic fsel_c_o,
	output logic programn_o,
	output logic bus_err_irq_o
);
	import soc_pkg::*;

	logic misc_sel;
	logic [DATA_W-1:0] misc_rdata;
	fsel_req_t fsel_req;
	logic timer_start;
	logic timer_expired;

	bus_decoder u_bus_decoder (
		.clk48m        (clk48m),
		.rst           (rst),
		.bus_req_i     (bus_req_i),
		.misc_rdata_i  (misc_rdata),
		.misc_sel_o    (misc_sel),
		.bus_rsp_o     (bus_rsp_o),
		.bus_err_irq_o (bus_err_irq_o)
	);

	misc_regs u_misc_regs (
		.clk48m       (clk48m),
		.rst          (rst),
		.misc_sel_i   (misc_sel),
		.bus_req_i    (bus_req_i),
		.btn_i        (btn_i),
		.genio_in_i   (genio_in_i),
		.misc_rdata_o (misc_rdata),
		.led_o        (led_o),
		.genio_out_o  (genio_out_o),
		.genio_oe_o   (genio_oe_o),
		.fsel_d_o     (fsel_d_o),
		.fsel_req_o   (fsel_req)
	);

	fsel_timer u_fsel_timer (
		.clk48m    (clk48m),
		.rst       (rst),
		.start_i   (timer_start),
		.fsel_c_o  (fsel_c_o),
		.expired_o (timer_expired)
	);

	reload_fsm u_reload_fsm (
		.clk48m        (clk48m),
		.rst           (rst),
		.fsel_req_i    (fsel_req),
		.expired_i     (timer_expired),
		.timer_start_o (timer_start),
		.programn_o    (programn_o)
	);

endmodule

/* sim/soc_misc_props.sv */
// ----------------------------------------
// bus and reload properties
// bound into the system-control slice top
// ----------------------------------------
`timescale 1ns/1ns

module soc_misc_props (
	input logic clk48m,
	input logic rst,
	input soc_pkg::bus_req_t bus_req_i,
	input soc_pkg::bus_rsp_t bus_rsp_o,
	input logic fsel_c_o,
	input logic programn_o
);

	// consecutive cycles fsel_c_o has already been high
	logic [2:0] c_high_run;

	always_ff @(posedge clk48m) begin
		if (rst) begin
			c_high_run <= '0;
		end else if (!fsel_c_o) begin
			c_high_run <= '0;
		end else if (c_high_run != 3'd7) begin
			c_high_run <= c_high_run + 1'b1;
		end
	end

	ready_on_valid: assert property (@(posedge clk48m) disable iff (rst)
		bus_req_i.valid |-> bus_rsp_o.ready)
		else $error("ready missing for a valid request");

	fsel_c_width: assert property (@(posedge clk48m) disable iff (rst)
		!(fsel_c_o && c_high_run >= 3'd3))
		else $error("fsel_c_o high for more than 3 cycles");

	programn_sticky: assert property (@(posedge clk48m) disable iff (rst)
		!programn_o |=> !programn_o)
		else $error("programn_o rose after falling");

endmodule

bind soc_misc_top soc_misc_props u_props (
	.clk48m     (clk48m),
	.rst        (rst),
	.bus_req_i  (bus_req_i),
	.bus_rsp_o  (bus_rsp_o),
	.fsel_c_o   (fsel_c_o),
	.programn_o (programn_o)
);

/* sim/tb_soc_misc.sv */
// ----------------------------------------
// testbench for the system-control slice
// replays bus accesses from the test data file
// ----------------------------------------
`timescale 1ns/1ns

module tb_soc_misc;
	import soc_pkg::*;

	localparam int CLK_HALF = 20;
	localparam int RST_CYCLES = 10;
	localparam int READY_TIMEOUT = 8;
	localparam int WATCH_CYCLES = 20;
	localparam int FSEL_C_CYCLES = 3;
	localparam int SEED = 24128;

	logic clk48m;
	logic rst;
	bus_req_t bus_req;
	bus_rsp_t bus_rsp;
	logic [BTN_W-1:0] btn_drive;
	logic [GENIO_W-1:0] genio_drive;
	logic [GENIO_W-1:0] genio_out;
	logic [GENIO_W-1:0] genio_oe;
	logic [LED_W-1:0] led;
	logic fsel_d;
	logic fsel_c;
	logic programn;
	logic bus_err_irq;

	// expected register contents
	logic [LED_W-1:0] led_m;
	logic [GENIO_W-1:0] out_m;
	logic [GENIO_W-1:0] oe_m;

	logic [DATA_W-1:0] rsp_rdata;
	logic rsp_irq;
	int test_errors;
	int total_errors;
	int tests_run;
	int tests_bad;
	bit in_test;
	bit run_aborted;
	string test_name;

	soc_misc_top UUT (
		.clk48m        (clk48m),
		.rst           (rst),
		.bus_req_i     (bus_req),
		.bus_rsp_o     (bus_rsp),
		.btn_i         (btn_drive),
		.genio_in_i    (genio_drive),
		.genio_out_o   (genio_out),
		.genio_oe_o    (genio_oe),
		.led_o         (led),
		.fsel_d_o      (fsel_d),
		.fsel_c_o      (fsel_c),
		.programn_o    (programn),
		.bus_err_irq_o (bus_err_irq)
	);

	always #CLK_HALF clk48m = ~clk48m;

	task automatic compare_value(input string name, input logic [DATA_W-1:0] got,
		input logic [DATA_W-1:0] exp);
		assert (got === exp) else begin
			$display("** Error %s: got %h, expected %h", name, got, exp);
			test_errors++;
		end
	endtask

	task automatic confirm(input bit cond, input string what);
		assert (cond) else begin
			$display("error: %s", what);
			test_errors++;
		end
	endtask

	task automatic audit_ports();
		compare_value("led_o", DATA_W'(led), DATA_W'(led_m));
		compare_value("genio_out_o", DATA_W'(genio_out), DATA_W'(out_m));
		compare_value("genio_oe_o", DATA_W'(genio_oe), DATA_W'(oe_m));
	endtask

	task automatic close_test();
		if (in_test) begin
			tests_run++;
			if (test_errors == 0) begin
				$display("%s: ok", test_name);
			end else begin
				$display("%s: %0d error(s)", test_name, test_errors);
				tests_bad++;
			end
		end
		total_errors += test_errors;
		test_errors = 0;
		in_test = 0;
	endtask

	function automatic string trim_line(input string s);
		string r;
		r = s;
		while (r.len() > 0 && (r.getc(r.len() - 1) == 8'h0a || r.getc(r.len() - 1) == 8'h0d
			|| r.getc(r.len() - 1) == " ")) begin
			r = r.substr(0, r.len() - 2);
		end
		return r;
	endfunction

	// ----------------------------------------
	// one bus access, completes when ready is seen
	// ----------------------------------------
	task automatic bus_access(input logic [DATA_W-1:0] addr, input logic [DATA_W-1:0] wdata,
		input logic [STRB_W-1:0] strb);
		int waited;
		bit seen;
		logic [31:0] rnd;
		waited = 0;
		seen = 0;
		@(negedge clk48m);
		rnd = $urandom();
		btn_drive = rnd[BTN_W-1:0];
		rnd = $urandom();
		genio_drive = rnd[GENIO_W-1:0];
		bus_req.valid = 1'b1;
		bus_req.addr = addr;
		bus_req.wdata = wdata;
		bus_req.wstrb = strb;
		while (!seen && waited < READY_TIMEOUT) begin
			#1;
			if (bus_rsp.ready) begin
				rsp_rdata = bus_rsp.rdata;
				rsp_irq = bus_err_irq;
				seen = 1;
			end else begin
				@(negedge clk48m);
				waited++;
			end
		end
		if (!seen) begin
			$display("timeout: no ready for the access to address %h", addr);
			test_errors++;
			run_aborted = 1;
		end
		// write edge
		@(posedge clk48m);
		@(negedge clk48m);
		bus_req = '0;
	endtask

	// mux clock pulse width and programn level after a flash select write
	task automatic watch_flash_select(input logic wbit, input logic exp_prog);
		int i;
		int run;
		int max_run;
		int high_total;
		int first_low;
		bit rose;
		run = 0;
		max_run = 0;
		high_total = 0;
		first_low = -1;
		rose = 0;
		compare_value("fsel_d_o", DATA_W'(fsel_d), DATA_W'(wbit));
		for (i = 0; i < WATCH_CYCLES; i++) begin
			if (fsel_c) begin
				run++;
				high_total++;
				if (run > max_run) begin
					max_run = run;
				end
			end else begin
				run = 0;
			end
			if (!programn && first_low < 0) begin
				first_low = i;
			end
			if (programn && first_low >= 0) begin
				rose = 1;
			end
			@(negedge clk48m);
		end
		confirm(high_total == FSEL_C_CYCLES && max_run == FSEL_C_CYCLES,
			"fsel_c_o was not high for exactly 3 consecutive cycles");
		if (exp_prog) begin
			confirm(first_low < 0, "programn_o went low without the reload key");
		end else begin
			confirm(first_low >= 0, "programn_o did not go low within 20 cycles");
			confirm(!rose, "programn_o rose again after it fell");
		end
	endtask

	task automatic run_line(input byte op, input logic [DATA_W-1:0] addr,
		input logic [DATA_W-1:0] wdata, input logic [DATA_W-1:0] expv);
		logic [4:0] off;
		logic mapped;
		logic [DATA_W-1:0] exp_rd;
		logic [BTN_W-1:0] btn_inv;
		off = addr[6:2];
		mapped = (addr[31:28] == REGION_MISC);
		if (op == "W") begin
			bus_access(addr, wdata, 4'hF);
			compare_value("bus_err_irq_o", DATA_W'(rsp_irq), '0);
			if (mapped) begin
				case (off)
					REG_LED: led_m = wdata[LED_W-1:0];
					REG_GENIO_OUT: out_m = wdata[GENIO_W-1:0];
					REG_GENIO_OE: oe_m = wdata[GENIO_W-1:0];
					REG_GENIO_W2S: out_m = out_m | wdata[GENIO_W-1:0];
					REG_GENIO_W2C: out_m = out_m & ~wdata[GENIO_W-1:0];
					REG_FLASH_SEL: watch_flash_select(wdata[0], expv[0]);
					default: begin
					end
				endcase
			end
		end else if (op == "R") begin
			bus_access(addr, '0, 4'h0);
			exp_rd = expv;
			// live inputs give the expected value here
			if (mapped && off == REG_BTN) begin
				btn_inv = ~btn_drive;
				exp_rd = DATA_W'(btn_inv);
			end else if (mapped && off == REG_GENIO_IN) begin
				exp_rd = DATA_W'(genio_drive);
			end
			compare_value("rdata", rsp_rdata, exp_rd);
			compare_value("bus_err_irq_o", DATA_W'(rsp_irq), '0);
		end else if (op == "E") begin
			bus_access(addr, wdata, (wdata != '0) ? 4'hF : 4'h0);
			compare_value("rdata", rsp_rdata, expv);
			compare_value("bus_err_irq_o", DATA_W'(rsp_irq), DATA_W'(1'b1));
		end else begin
			confirm(0, "unknown operation in the test data file");
		end
		audit_ports();
	endtask

	initial begin
		int fd;
		int code;
		int fields;
		string line;
		logic [DATA_W-1:0] addr_v;
		logic [DATA_W-1:0] wdata_v;
		logic [DATA_W-1:0] exp_v;
		int unsigned seed_val;
		seed_val = $urandom(SEED);
		clk48m = 1'b0;
		rst = 1'b1;
		bus_req = '0;
		btn_drive = '0;
		genio_drive = '0;
		led_m = '0;
		out_m = '0;
		oe_m = '0;
		rsp_rdata = '0;
		rsp_irq = 1'b0;
		test_errors = 0;
		total_errors = 0;
		tests_run = 0;
		tests_bad = 0;
		run_aborted = 0;
		repeat (RST_CYCLES) @(negedge clk48m);
		rst = 1'b0;

		// ----------------------------------------
		// reset values
		// ----------------------------------------
		test_name = "reset_values";
		in_test = 1;
		@(negedge clk48m);
		confirm(programn === 1'b1, "programn_o is not high after reset");
		confirm(fsel_c === 1'b0 && fsel_d === 1'b0, "flash select outputs not low after reset");
		confirm(bus_err_irq === 1'b0, "bus_err_irq_o high with valid low");
		audit_ports();
		close_test();

		fd = $fopen("sim/soc_misc_testdata.txt", "r");
		if (fd == 0) begin
			$display("could not open the test data file");
			run_aborted = 1;
		end
		while (fd != 0 && !run_aborted && !$feof(fd)) begin
			code = $fgets(line, fd);
			line = trim_line(line);
			if (code > 0 && line.len() > 0 && line.getc(0) != "#") begin
				if (line.getc(0) == "@") begin
					close_test();
					test_name = line.substr(2, line.len() - 1);
					in_test = 1;
				end else begin
					fields = $sscanf(line.substr(1, line.len() - 1), "%h %h %h",
						addr_v, wdata_v, exp_v);
					if (fields == 3) begin
						run_line(line.getc(0), addr_v, wdata_v, exp_v);
					end else begin
						confirm(0, "malformed line in the test data file");
					end
				end
			end
		end
		close_test();
		if (fd != 0) begin
			$fclose(fd);
		end
		$display("%0d tests run, %0d with errors, %0d errors in total",
			tests_run, tests_bad, total_errors);
		if (total_errors == 0 && !run_aborted && tests_run > 1) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule

/* sim/soc_misc_testdata.txt */
# op addr wdata expected (hex); W write, R read, E unmapped access (a write when wdata is nonzero)
# W to flash select expects the programn level; BTN and GENIO_IN reads use the driven inputs
@ led_genio_rw
W 20000000 FFFFFFFF 00000000
R 20000000 00000000 000001FF
W 20000000 000000A5 00000000
R 20000000 00000000 000000A5
W 20000048 FFFFFFFF 00000000
R 20000048 00000000 3FFFFFFF
W 2000004C D2345678 00000000
R 2000004C 00000000 12345678
@ genio_set_clear
W 20000048 00F0F00F 00000000
W 20000050 0F000F00 00000000
R 20000048 00000000 0FF0FF0F
W 20000054 C0F0000F 00000000
R 20000048 00000000 0F00FF00
@ readonly_regs
R 20000004 00000000 00000000
R 20000008 00000000 00008000
R 20000044 00000000 00000000
R 20000014 00000000 00000000
R 20000050 00000000 00000000
@ bus_error
E 00000000 00000000 DEADBEEF
E 30000000 FFFFFFFF DEADBEEF
E F0000048 3FFFFFFF DEADBEEF
R 20000000 00000000 000000A5
R 20000048 00000000 0F00FF00
@ flash_select
W 20000034 00000001 00000001
R 20000034 00000000 00000001
W 20000034 D0F1A401 00000001
W 20000034 00000000 00000001
R 20000034 00000000 00000000
@ reload
W 20000034 D0F1A501 00000000
W 20000034 00000001 00000000
R 20000034 00000000 00000001

/* files.f */
common/soc_pkg.sv
misc/fsel_timer.sv
misc/reload_fsm.sv
misc/misc_regs.sv
source/bus_decoder.sv
source/soc_misc_top.sv
sim/soc_misc_props.sv
sim/tb_soc_misc.sv

/* Makefile */
VERILATOR = verilator
VFLAGS = --binary --timing --assert -j 0
TOP = tb_soc_misc
FILELIST = files.f
OBJ_DIR = obj_dir
LOG = sim.log
PASS_MSG = test passed

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
